/* Bender.yml */
package:
  name: bk_mem

export_include_dirs:
  - hdl

sources:
  - hdl/bk_mem_pkg.sv
  - hdl/sdram_req_if.sv
  - hdl/bk_page_reg.sv
  - hdl/bk_bus_port.sv
  - hdl/sdram_refresh_timer.sv
  - hdl/sdram_ctrl.sv
  - hdl/bk_mem_top.sv
  - target: test
    files:
      - verif/sdram_model.sv
      - verif/bk_mem_tb.sv

/* hdl/bk_bus_port.sv */
//////////////////////////////////////////////////////////////////////
// CPU bus port
// strobe capture, BK0011M address map, ROM write drop and acknowledge
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "bk_mem_config.svh"

module bk_bus_port (
	input  logic                  clk_037,
	input  logic                  arst_n_i,
	input  logic                  stb_i,
	input  logic                  we_i,
	input  bk_mem_pkg::byte_sel_t sel_i,
	input  bk_mem_pkg::cpu_addr_t adr_i,
	input  bk_mem_pkg::data_t     dat_i,
	output bk_mem_pkg::data_t     dat_o,
	output logic                  ack_o,
	input  bk_mem_pkg::data_t     page_i,
	sdram_req_if.port             req
);

	// page code to 16 KB RAM base
	function automatic bk_mem_pkg::phys_addr_t page_base(input logic [2:0] code);
		case (code)
			3'd6:    page_base = 25'h000000;
			3'd0:    page_base = 25'h004000;
			3'd2:    page_base = 25'h008000;
			3'd3:    page_base = 25'h00C000;
			3'd4:    page_base = 25'h010000;
			3'd1:    page_base = 25'h014000;
			3'd7:    page_base = 25'h018000;
			default: page_base = 25'h01C000;
		endcase
	endfunction

	logic                   stb_q;    // strobe last cycle
	logic                   map_q;    // request captured, mapping now
	logic                   drop_q;   // rom write, ack next
	logic                   valid_q;
	logic                   ack_q;
	logic                   we_q;
	bk_mem_pkg::cpu_addr_t  adr_q;
	bk_mem_pkg::byte_sel_t  sel_q;
	bk_mem_pkg::data_t      wdata_q;
	bk_mem_pkg::word_addr_t addr_q;
	bk_mem_pkg::data_t      rdata_q;
	bk_mem_pkg::phys_addr_t phys;
	logic                   new_stb;
	logic                   rom_wr;

	always_comb begin
		case (adr_q[15:14])
			2'b00:   phys = {11'd0, adr_q[13:0]};
			2'b01:   phys = page_base(page_i[14:12]) | {11'd0, adr_q[13:0]};
			2'b10:   phys = page_base(page_i[10:8]) | {11'd0, adr_q[13:0]};
			// 110 system rom, 111 empty area
			default: phys = (adr_q[13] ? 25'h100000 : 25'h0F0000) | {12'd0, adr_q[12:0]};
		endcase
	end

	assign new_stb = stb_i && !stb_q;
	assign rom_wr  = we_q && (phys >= `BK_ROM_BASE);

	always_ff @(posedge clk_037 or negedge arst_n_i) begin
		if (!arst_n_i) begin
			stb_q   <= 1'b0;
			map_q   <= 1'b0;
			drop_q  <= 1'b0;
			valid_q <= 1'b0;
			ack_q   <= 1'b0;
		end else begin
			stb_q  <= stb_i;
			map_q  <= new_stb;
			drop_q <= map_q && rom_wr;
			if (map_q && !rom_wr) begin
				valid_q <= 1'b1;
			end else if (req.done) begin
				valid_q <= 1'b0;
			end
			ack_q <= drop_q || req.done;
		end
	end

	always_ff @(posedge clk_037) begin
		if (new_stb) begin
			adr_q   <= adr_i;
			we_q    <= we_i;
			sel_q   <= sel_i;
			wdata_q <= dat_i;
		end
		if (map_q)
			addr_q <= phys[24:1];  // word address
		if (req.done && !we_q)
			rdata_q <= req.rdata;
	end

	assign req.valid = valid_q;
	assign req.we    = we_q;
	assign req.addr  = addr_q;
	assign req.wtbt  = we_q ? sel_q : 2'b11;
	assign req.wdata = wdata_q;
	assign dat_o     = rdata_q;  // held until next read
	assign ack_o     = ack_q;

	// the cpu must still be strobing when the ack is produced
	a_ack_with_stb : assert property (@(posedge clk_037) disable iff (!arst_n_i)
		ack_o |-> $past(stb_i))
		else $error("bk_bus_port: ack without strobe");

endmodule

/* hdl/bk_mem_config.svh */
//////////////////////////////////////////////////////////////////////
// BK0011M memory subsystem constants
// SDRAM timing in clk_037 cycles, mode word and ROM boundary
//////////////////////////////////////////////////////////////////////

`ifndef BK_MEM_CONFIG_SVH
`define BK_MEM_CONFIG_SVH

// reset to end of init, 100 us plus margin
`define BK_SDRAM_STARTUP_CYCLES 10100

// 64 ms over 4096 rows, less a little
`define BK_SDRAM_REFRESH_CYCLES 1524

`define BK_SDRAM_RCD 3  // active to read/write
`define BK_SDRAM_CAS 3  // cas latency
`define BK_SDRAM_TRC 6  // idle after auto refresh
`define BK_SDRAM_TRP 3  // idle after auto precharge access

// mode register word
//   [12:10] reserved
//   [9]     single location write
//   [8:7]   standard operation
//   [6:4]   cas latency 3
//   [3]     sequential
//   [2:0]   burst length 1
`define BK_SDRAM_MODE 13'b000_1_00_011_0_000

// everything from here up is read only for the cpu
`define BK_ROM_BASE 25'h0E0000

`endif

/* hdl/bk_mem_pkg.sv */
//////////////////////////////////////////////////////////////////////
// BK0011M memory subsystem types
// address, data and command types, sequencer state encodings
//////////////////////////////////////////////////////////////////////

package bk_mem_pkg;

	typedef logic [15:0] cpu_addr_t;   // cpu bus address
	typedef logic [24:0] phys_addr_t;  // mapped byte address
	typedef logic [23:0] word_addr_t;  // bank 23:22, row 21:9, col 8:0
	typedef logic [15:0] data_t;
	typedef logic [1:0]  byte_sel_t;   // bit 1 is the high byte

	// {ncs, nras, ncas, nwe}
	typedef enum logic [3:0] {
		CMD_INHIBIT      = 4'b1111,
		CMD_NOP          = 4'b0111,
		CMD_ACTIVE       = 4'b0011,
		CMD_READ         = 4'b0101,
		CMD_WRITE        = 4'b0100,
		CMD_PRECHARGE    = 4'b0010,
		CMD_AUTO_REFRESH = 4'b0001,
		CMD_LOAD_MODE    = 4'b0000
	} sdram_cmd_t;

	// startup sequence steps, one cycle each except wait and done
	typedef enum logic [2:0] {
		INIT_WAIT,
		INIT_PRECHARGE,
		INIT_REFRESH1,
		INIT_REFRESH2,
		INIT_LOAD_MODE,
		INIT_DONE
	} init_step_t;

	typedef enum logic [2:0] {
		ST_INIT,
		ST_IDLE,
		ST_REFRESH_WAIT,
		ST_OPEN,
		ST_READ,
		ST_READ_WAIT,
		ST_WRITE,
		ST_PRE_WAIT
	} ctrl_state_t;

endpackage

/* hdl/bk_mem_top.sv */
//////////////////////////////////////////////////////////////////////
// BK0011M memory subsystem top
// CPU bus port and page register in front of the SDRAM controller
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module bk_mem_top (
	input  logic                  clk_037,
	input  logic                  arst_n_i,
	input  logic                  stb_i,
	input  logic                  we_i,
	input  bk_mem_pkg::byte_sel_t sel_i,
	input  bk_mem_pkg::cpu_addr_t adr_i,
	input  bk_mem_pkg::data_t     dat_i,
	output bk_mem_pkg::data_t     dat_o,
	output logic                  ack_o,
	input  logic                  page_wr_i,
	input  bk_mem_pkg::data_t     page_dat_i,
	inout  wire bk_mem_pkg::data_t sdram_dq_io,
	output logic [12:0]           sdram_a_o,
	output logic [1:0]            sdram_ba_o,
	output logic                  sdram_dqml_o,
	output logic                  sdram_dqmh_o,
	output logic                  sdram_ncs_o,
	output logic                  sdram_nras_o,
	output logic                  sdram_ncas_o,
	output logic                  sdram_nwe_o,
	output logic                  sdram_cke_o
);

	bk_mem_pkg::data_t      page;
	bk_mem_pkg::init_step_t init_step;
	logic                   init_done;
	logic                   refresh_due;
	logic                   refresh_ack;
	bk_mem_pkg::sdram_cmd_t sdram_cmd;
	logic [1:0]             sdram_dqm;
	bk_mem_pkg::data_t      dq_out;
	logic                   dq_oe;

	sdram_req_if i_req_if ();

	bk_page_reg i_page_reg (
		.clk_037    (clk_037),
		.arst_n_i   (arst_n_i),
		.page_wr_i  (page_wr_i),
		.page_dat_i (page_dat_i),
		.page_o     (page)
	);

	bk_bus_port i_bus_port (
		.clk_037  (clk_037),
		.arst_n_i (arst_n_i),
		.stb_i    (stb_i),
		.we_i     (we_i),
		.sel_i    (sel_i),
		.adr_i    (adr_i),
		.dat_i    (dat_i),
		.dat_o    (dat_o),
		.ack_o    (ack_o),
		.page_i   (page),
		.req      (i_req_if.port)
	);

	sdram_refresh_timer i_refresh_timer (
		.clk_037       (clk_037),
		.arst_n_i      (arst_n_i),
		.init_step_o   (init_step),
		.init_done_o   (init_done),
		.refresh_due_o (refresh_due),
		.refresh_ack_i (refresh_ack)
	);

	sdram_ctrl i_sdram_ctrl (
		.clk_037       (clk_037),
		.arst_n_i      (arst_n_i),
		.init_step_i   (init_step),
		.init_done_i   (init_done),
		.refresh_due_i (refresh_due),
		.refresh_ack_o (refresh_ack),
		.req           (i_req_if.ctrl),
		.sdram_cmd_o   (sdram_cmd),
		.sdram_a_o     (sdram_a_o),
		.sdram_ba_o    (sdram_ba_o),
		.sdram_dqm_o   (sdram_dqm),
		.sdram_cke_o   (sdram_cke_o),
		.dq_o          (dq_out),
		.dq_oe_o       (dq_oe),
		.dq_i          (sdram_dq_io)
	);

	// command code onto the chip pins
	assign {sdram_ncs_o, sdram_nras_o, sdram_ncas_o, sdram_nwe_o} = sdram_cmd;
	assign sdram_dqml_o = sdram_dqm[0];
	assign sdram_dqmh_o = sdram_dqm[1];
	assign sdram_dq_io  = dq_oe ? dq_out : 'z;  // driven only for writes

endmodule

/* hdl/bk_page_reg.sv */
//////////////////////////////////////////////////////////////////////
// BK0011M page register
// loaded from system register writes that carry the page bit 11
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module bk_page_reg (
	input  logic              clk_037,
	input  logic              arst_n_i,
	input  logic              page_wr_i,
	input  bk_mem_pkg::data_t page_dat_i,
	output bk_mem_pkg::data_t page_o
);

	bk_mem_pkg::data_t page_q;

	// without bit 11 the write is meant for the other sysreg functions
	always_ff @(posedge clk_037 or negedge arst_n_i) begin
		if (!arst_n_i) begin
			page_q <= '0;
		end else if (page_wr_i && page_dat_i[11]) begin
			page_q <= page_dat_i;
		end
	end

	assign page_o = page_q;  // [14:12] window 1, [10:8] window 2

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	a_page_qualified : assert property (@(posedge clk_037) disable iff (!arst_n_i)
		!$stable(page_o) |-> $past(page_wr_i && page_dat_i[11]))
		else $error("bk_page_reg: page changed without a qualifying write");

endmodule

/* hdl/sdram_ctrl.sv */
//////////////////////////////////////////////////////////////////////
// SDRAM command sequencer
// init commands, auto refresh, single word reads and masked writes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "bk_mem_config.svh"

module sdram_ctrl (
	input  logic                   clk_037,
	input  logic                   arst_n_i,
	input  bk_mem_pkg::init_step_t init_step_i,
	input  logic                   init_done_i,
	input  logic                   refresh_due_i,
	output logic                   refresh_ack_o,
	sdram_req_if.ctrl              req,
	output bk_mem_pkg::sdram_cmd_t sdram_cmd_o,
	output logic [12:0]            sdram_a_o,
	output logic [1:0]             sdram_ba_o,
	output logic [1:0]             sdram_dqm_o,
	output logic                   sdram_cke_o,
	output bk_mem_pkg::data_t      dq_o,
	output logic                   dq_oe_o,
	input  bk_mem_pkg::data_t      dq_i
);

	localparam int WAIT_W = 4;

	bk_mem_pkg::ctrl_state_t state_q;
	logic [WAIT_W-1:0]       wait_q;   // cycles left in a timed state
	bk_mem_pkg::sdram_cmd_t  cmd_q;
	logic [12:0]             a_q;
	logic [1:0]              ba_q;
	logic [1:0]              dqm_q;
	logic                    oe_q;
	logic                    done_q;
	logic                    ref_ack_q;
	bk_mem_pkg::data_t       dq_q;
	bk_mem_pkg::data_t       rdata_q;
	logic                    wait_end;

	assign wait_end = (wait_q == '0);

	//////////////////////////////////////////////////////////////////////
	// command sequencer
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_037 or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q   <= bk_mem_pkg::ST_INIT;
			wait_q    <= '0;
			cmd_q     <= bk_mem_pkg::CMD_INHIBIT;
			a_q       <= '0;
			ba_q      <= '0;
			dqm_q     <= 2'b11;
			oe_q      <= 1'b0;
			done_q    <= 1'b0;
			ref_ack_q <= 1'b0;
		end else begin
			cmd_q     <= bk_mem_pkg::CMD_NOP;
			a_q       <= '0;
			ba_q      <= '0;
			done_q    <= 1'b0;
			ref_ack_q <= 1'b0;
			case (state_q)
				bk_mem_pkg::ST_INIT: begin
					case (init_step_i)
						bk_mem_pkg::INIT_PRECHARGE: begin
							cmd_q  <= bk_mem_pkg::CMD_PRECHARGE;
							a_q[10] <= 1'b1;  // all banks
						end
						bk_mem_pkg::INIT_REFRESH1,
						bk_mem_pkg::INIT_REFRESH2: cmd_q <= bk_mem_pkg::CMD_AUTO_REFRESH;
						bk_mem_pkg::INIT_LOAD_MODE: begin
							cmd_q <= bk_mem_pkg::CMD_LOAD_MODE;
							a_q   <= `BK_SDRAM_MODE;
						end
						default: cmd_q <= bk_mem_pkg::CMD_NOP;
					endcase
					if (init_done_i)
						state_q <= bk_mem_pkg::ST_IDLE;
				end
				bk_mem_pkg::ST_IDLE: begin
					if (refresh_due_i) begin  // refresh first
						cmd_q     <= bk_mem_pkg::CMD_AUTO_REFRESH;
						ref_ack_q <= 1'b1;
						wait_q    <= WAIT_W'(`BK_SDRAM_TRC - 1);
						state_q   <= bk_mem_pkg::ST_REFRESH_WAIT;
					end else if (req.valid) begin
						cmd_q   <= bk_mem_pkg::CMD_ACTIVE;
						a_q     <= req.addr[21:9];
						ba_q    <= req.addr[23:22];
						wait_q  <= WAIT_W'(`BK_SDRAM_RCD - 1);
						state_q <= bk_mem_pkg::ST_OPEN;
					end
				end
				bk_mem_pkg::ST_OPEN: begin
					if (wait_end) begin
						a_q  <= {2'b00, 1'b1, 1'b0, req.addr[8:0]};  // A10 auto precharge
						ba_q <= req.addr[23:22];
						if (req.we) begin
							cmd_q   <= bk_mem_pkg::CMD_WRITE;
							dqm_q   <= ~req.wtbt;
							oe_q    <= 1'b1;
							state_q <= bk_mem_pkg::ST_WRITE;
						end else begin
							cmd_q   <= bk_mem_pkg::CMD_READ;
							dqm_q   <= 2'b00;
							state_q <= bk_mem_pkg::ST_READ;
						end
					end else begin
						wait_q <= wait_q - 1'b1;
					end
				end
				bk_mem_pkg::ST_WRITE: begin
					done_q  <= 1'b1;
					oe_q    <= 1'b0;
					dqm_q   <= 2'b11;
					wait_q  <= WAIT_W'(`BK_SDRAM_TRP - 1);
					state_q <= bk_mem_pkg::ST_PRE_WAIT;
				end
				bk_mem_pkg::ST_READ: begin
					wait_q  <= WAIT_W'(`BK_SDRAM_CAS - 1);
					state_q <= bk_mem_pkg::ST_READ_WAIT;
				end
				bk_mem_pkg::ST_READ_WAIT: begin
					if (wait_end) begin  // data on dq now
						done_q  <= 1'b1;
						dqm_q   <= 2'b11;
						wait_q  <= WAIT_W'(`BK_SDRAM_TRP - 1);
						state_q <= bk_mem_pkg::ST_PRE_WAIT;
					end else begin
						wait_q <= wait_q - 1'b1;
					end
				end
				bk_mem_pkg::ST_REFRESH_WAIT,
				bk_mem_pkg::ST_PRE_WAIT: begin
					if (wait_end)
						state_q <= bk_mem_pkg::ST_IDLE;
					else
						wait_q <= wait_q - 1'b1;
				end
				default: state_q <= bk_mem_pkg::ST_INIT;
			endcase
		end
	end

	// write data and read capture
	always_ff @(posedge clk_037) begin
		if (state_q == bk_mem_pkg::ST_OPEN && wait_end && req.we)
			dq_q <= req.wdata;
		if (state_q == bk_mem_pkg::ST_READ_WAIT && wait_end)
			rdata_q <= dq_i;
	end

	assign sdram_cmd_o   = cmd_q;
	assign sdram_a_o     = a_q;
	assign sdram_ba_o    = ba_q;
	assign sdram_dqm_o   = dqm_q;
	assign sdram_cke_o   = 1'b1;  // no power down
	assign dq_o          = dq_q;
	assign dq_oe_o       = oe_q;
	assign refresh_ack_o = ref_ack_q;
	assign req.done      = done_q;
	assign req.rdata     = rdata_q;

	// done only ends an access that the port still holds
	a_done_in_access : assert property (@(posedge clk_037) disable iff (!arst_n_i)
		req.done |-> state_q == bk_mem_pkg::ST_PRE_WAIT && $past(req.valid))
		else $error("sdram_ctrl: done outside an access");

endmodule

/* hdl/sdram_refresh_timer.sv */
//////////////////////////////////////////////////////////////////////
// SDRAM startup and refresh timer
// paces the init commands, then requests periodic auto refresh
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "bk_mem_config.svh"

module sdram_refresh_timer (
	input  logic                   clk_037,
	input  logic                   arst_n_i,
	output bk_mem_pkg::init_step_t init_step_o,
	output logic                   init_done_o,
	output logic                   refresh_due_o,
	input  logic                   refresh_ack_i
);

	localparam int CNT_W = $clog2(`BK_SDRAM_STARTUP_CYCLES + 1);

	logic [CNT_W-1:0]       cnt_q;
	logic                   init_done_q;
	logic                   due_q;
	bk_mem_pkg::init_step_t step_q;

	always_ff @(posedge clk_037 or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cnt_q       <= CNT_W'(`BK_SDRAM_STARTUP_CYCLES - 1);
			init_done_q <= 1'b0;
			due_q       <= 1'b0;
			step_q      <= bk_mem_pkg::INIT_WAIT;
		end else begin
			step_q <= init_done_q ? bk_mem_pkg::INIT_DONE : bk_mem_pkg::INIT_WAIT;
			if (!init_done_q) begin
				// refreshes 8 cycles apart, well over tRC
				case (cnt_q)
					CNT_W'(31): step_q <= bk_mem_pkg::INIT_PRECHARGE;
					CNT_W'(23): step_q <= bk_mem_pkg::INIT_REFRESH1;
					CNT_W'(15): step_q <= bk_mem_pkg::INIT_REFRESH2;
					CNT_W'(7):  step_q <= bk_mem_pkg::INIT_LOAD_MODE;
					default:    ;
				endcase
			end
			if (refresh_ack_i)
				due_q <= 1'b0;
			if (cnt_q == '0) begin
				cnt_q       <= CNT_W'(`BK_SDRAM_REFRESH_CYCLES - 1);
				init_done_q <= 1'b1;
				step_q      <= bk_mem_pkg::INIT_DONE;
				if (init_done_q)
					due_q <= 1'b1;  // set wins over a same cycle ack
			end else begin
				cnt_q <= cnt_q - 1'b1;
			end
		end
	end

	assign init_step_o   = step_q;
	assign init_done_o   = init_done_q;
	assign refresh_due_o = due_q;

	a_due_held : assert property (@(posedge clk_037) disable iff (!arst_n_i)
		$fell(refresh_due_o) |-> $past(refresh_ack_i))
		else $error("sdram_refresh_timer: refresh request dropped without ack");

endmodule

/* hdl/sdram_req_if.sv */
//////////////////////////////////////////////////////////////////////
// single word request channel from the bus port to the SDRAM sequencer
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface sdram_req_if ();

	logic                   valid;  // held until done
	logic                   we;
	bk_mem_pkg::word_addr_t addr;
	bk_mem_pkg::byte_sel_t  wtbt;   // byte enables, 11 on reads
	bk_mem_pkg::data_t      wdata;
	logic                   done;   // one cycle pulse
	bk_mem_pkg::data_t      rdata;  // valid with done on reads

	modport port (
		output valid, we, addr, wtbt, wdata,
		input  done, rdata
	);

	modport ctrl (
		input  valid, we, addr, wtbt, wdata,
		output done, rdata
	);

endinterface

/* src.f */
+incdir+hdl
hdl/bk_mem_pkg.sv
hdl/sdram_req_if.sv
hdl/bk_page_reg.sv
hdl/bk_bus_port.sv
hdl/sdram_refresh_timer.sv
hdl/sdram_ctrl.sv
hdl/bk_mem_top.sv
verif/sdram_model.sv
verif/bk_mem_tb.sv

/* verif/bk_mem_tb.sv */
//////////////////////////////////////////////////////////////////////
// BK0011M memory subsystem testbench
// directed CPU bus accesses against the behavioural SDRAM
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "bk_mem_config.svh"

module bk_mem_tb;

	localparam int          CLK_HALF       = 5;
	localparam int          N_RAND         = 16;
	localparam int          N_REF_READS    = 640;  // about five refresh intervals
	localparam int          N_ACCESS       = 1 + 2 * N_RAND + 4 + 4 + 1 + 2 + N_REF_READS;
	localparam int          TIMEOUT_CYCLES = `BK_SDRAM_STARTUP_CYCLES + 200 * N_ACCESS;
	localparam logic [31:0] SEED           = 32'h6e75;

	logic        clk_037 = 1'b0;
	logic        arst_n;
	logic        stb;
	logic        we;
	logic [1:0]  sel;
	logic [15:0] adr;
	logic [15:0] wdat;
	logic [15:0] rdat;
	logic        ack;
	logic        page_wr;
	logic [15:0] page_dat;
	wire  [15:0] sdram_dq;
	logic [12:0] sdram_a;
	logic [1:0]  sdram_ba;
	logic        dqml;
	logic        dqmh;
	logic        ncs;
	logic        nras;
	logic        ncas;
	logic        nwe;
	logic        cke;
	int          refresh_cnt;
	logic [12:0] mode_word;

	logic [31:0] lfsr_state = SEED;
	logic [15:0] shadow [65536];  // expected content of written words
	bit          shadow_ok [65536];
	logic [15:0] page_cur = '0;
	int          cycle = 0;
	int          test_errs = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          errs_total = 0;

	always #(CLK_HALF) clk_037 = ~clk_037;

	always @(posedge clk_037)
		cycle <= cycle + 1;

	bk_mem_top i_bk_mem_top (
		.clk_037      (clk_037),
		.arst_n_i     (arst_n),
		.stb_i        (stb),
		.we_i         (we),
		.sel_i        (sel),
		.adr_i        (adr),
		.dat_i        (wdat),
		.dat_o        (rdat),
		.ack_o        (ack),
		.page_wr_i    (page_wr),
		.page_dat_i   (page_dat),
		.sdram_dq_io  (sdram_dq),
		.sdram_a_o    (sdram_a),
		.sdram_ba_o   (sdram_ba),
		.sdram_dqml_o (dqml),
		.sdram_dqmh_o (dqmh),
		.sdram_ncs_o  (ncs),
		.sdram_nras_o (nras),
		.sdram_ncas_o (ncas),
		.sdram_nwe_o  (nwe),
		.sdram_cke_o  (cke)
	);

	sdram_model i_sdram_model (
		.clk_037       (clk_037),
		.cke_i         (cke),
		.ncs_i         (ncs),
		.nras_i        (nras),
		.ncas_i        (ncas),
		.nwe_i         (nwe),
		.ba_i          (sdram_ba),
		.a_i           (sdram_a),
		.dqml_i        (dqml),
		.dqmh_i        (dqmh),
		.dq_io         (sdram_dq),
		.refresh_cnt_o (refresh_cnt),
		.mode_o        (mode_word)
	);

	//////////////////////////////////////////////////////////////////////
	// reference model of the address map and memory
	//////////////////////////////////////////////////////////////////////

	// galois lfsr, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        b;
		r = '0;
		for (int i = 0; i < n; i++) begin
			b          = lfsr_state[0];
			lfsr_state = (lfsr_state >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
			r          = {r[30:0], b};
		end
		return r;
	endfunction

	// 16 KB slot number of a page code
	function automatic logic [2:0] window_slot(input logic [2:0] code);
		case (code)
			3'd6:    return 3'd0;
			3'd0:    return 3'd1;
			3'd2:    return 3'd2;
			3'd3:    return 3'd3;
			3'd4:    return 3'd4;
			3'd1:    return 3'd5;
			3'd7:    return 3'd6;
			default: return 3'd7;
		endcase
	endfunction

	function automatic logic [24:0] cpu_to_phys(input logic [15:0] a, input logic [15:0] pg);
		logic [2:0] code;
		code = a[15] ? pg[10:8] : pg[14:12];
		case (a[15:14])
			2'b00:   return {11'd0, a[13:0]};
			2'b01,
			2'b10:   return {8'd0, window_slot(code), 14'd0} + {11'd0, a[13:0]};
			default: return (a[13] ? 25'h100000 : 25'h0F0000) + {12'd0, a[12:0]};
		endcase
	endfunction

	function automatic logic [15:0] expect_word(input logic [24:0] phys);
		logic [23:0] wa;
		wa = phys[24:1];
		if (wa < 24'h10000 && shadow_ok[wa[15:0]])
			return shadow[wa[15:0]];
		return wa[15:0] ^ 16'hA5A5;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// bus driver tasks
	//////////////////////////////////////////////////////////////////////

	// lat counts clocks after the one that first saw the strobe
	task automatic bus_access(input logic w, input logic [1:0] s, input logic [15:0] a,
			input logic [15:0] d, output logic [15:0] rd, output int lat);
		stb  = 1'b1;
		we   = w;
		sel  = s;
		adr  = a;
		wdat = d;
		lat  = -1;
		do begin
			@(negedge clk_037);
			lat++;
		end while (!ack);
		rd  = rdat;
		stb = 1'b0;
		we  = 1'b0;
		@(negedge clk_037);  // strobe low for one cycle
	endtask

	task automatic write_word(input logic [15:0] a, input logic [1:0] s,
			input logic [15:0] d, output int lat);
		logic [24:0] phys;
		logic [15:0] rd;
		logic [15:0] w;
		phys = cpu_to_phys(a, page_cur);
		bus_access(1'b1, s, a, d, rd, lat);
		if (phys < `BK_ROM_BASE) begin
			w = expect_word(phys);
			if (s[0])
				w[7:0] = d[7:0];
			if (s[1])
				w[15:8] = d[15:8];
			shadow[phys[16:1]]    = w;
			shadow_ok[phys[16:1]] = 1'b1;
		end
	endtask

	task automatic read_word(input logic [15:0] a, output logic [15:0] rd);
		int lat;
		bus_access(1'b0, 2'b11, a, 16'h0000, rd, lat);
	endtask

	task automatic page_write(input logic [15:0] val);
		page_dat = val;
		page_wr  = 1'b1;
		@(negedge clk_037);
		page_wr  = 1'b0;
		if (val[11])
			page_cur = val;  // no page bit, no change
	endtask

	task automatic end_test(input string name);
		tests_run++;
		errs_total += test_errs;
		if (test_errs == 0) begin
			$display("%s: passed", name);
		end else begin
			tests_failed++;
			$display("%s: failed with %0d errors", name, test_errs);
		end
		test_errs = 0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_startup();
		logic [15:0] rd;
		logic [15:0] exp;
		exp = expect_word(cpu_to_phys(16'o001232, page_cur));
		read_word(16'o001232, rd);
		if (cycle < `BK_SDRAM_STARTUP_CYCLES) begin
			$display("startup: read finished at cycle %0d, before init ended", cycle);
			test_errs++;
		end
		if (mode_word !== 13'h0230) begin
			$display("error startup: expected mode %h, actual %h", 13'h0230, mode_word);
			test_errs++;
		end
		if (refresh_cnt != 2) begin
			$display("error startup: expected %0d refreshes, actual %0d", 2, refresh_cnt);
			test_errs++;
		end
		if (rd !== exp) begin
			$display("error startup: expected %h, actual %h", exp, rd);
			test_errs++;
		end
		end_test("startup");
	endtask

	task automatic test_byte_writes();
		logic [15:0] addrs [N_RAND];
		logic [31:0] r;
		logic [15:0] rd;
		logic [15:0] exp;
		logic [15:0] old;
		int          lat;
		for (int i = 0; i < N_RAND; i++) begin
			r        = rand_bits(13);
			addrs[i] = {2'b00, r[12:0], 1'b0};
			r        = rand_bits(16);
			write_word(addrs[i], 2'b11, r[15:0], lat);
		end
		for (int i = 0; i < N_RAND; i++) begin
			exp = expect_word(cpu_to_phys(addrs[i], page_cur));
			read_word(addrs[i], rd);
			if (rd !== exp) begin
				$display("error byte_writes: expected %h, actual %h", exp, rd);
				test_errs++;
			end
		end
		// low byte alone, then high byte alone
		for (int i = 0; i < 2; i++) begin
			old = expect_word(cpu_to_phys(addrs[i], page_cur));
			r   = rand_bits(16);
			write_word(addrs[i], i ? 2'b10 : 2'b01, r[15:0], lat);
			exp = i ? {r[15:8], old[7:0]} : {old[15:8], r[7:0]};
			read_word(addrs[i], rd);
			if (rd !== exp) begin
				$display("error byte_writes: expected %h, actual %h", exp, rd);
				test_errs++;
			end
		end
		end_test("byte_writes");
	endtask

	task automatic test_paging();
		logic [31:0] r;
		logic [2:0]  code;
		logic [15:0] off;
		logic [15:0] d;
		logic [15:0] rd;
		logic [15:0] exp;
		int          lat;
		r    = rand_bits(3);
		code = r[2:0];
		page_write({1'b0, code, 1'b1, code, 8'h00});
		r    = rand_bits(13);
		off  = {3'b000, r[12:0]} << 1;
		r    = rand_bits(16);
		d    = r[15:0];
		write_word(16'h4000 | off, 2'b11, d, lat);
		read_word(16'h8000 | off, rd);
		if (rd !== d) begin
			$display("error paging: expected %h, actual %h", d, rd);
			test_errs++;
		end
		page_write({1'b0, code + 3'd3, 1'b1, code, 8'h00});
		exp = expect_word(cpu_to_phys(16'h4000 | off, page_cur));
		read_word(16'h4000 | off, rd);
		if (rd !== exp) begin
			$display("error paging: expected %h, actual %h", exp, rd);
			test_errs++;
		end
		// second window still on the old code
		exp = expect_word(cpu_to_phys(16'h8000 | off, page_cur));
		read_word(16'h8000 | off, rd);
		if (rd !== exp) begin
			$display("error paging: expected %h, actual %h", exp, rd);
			test_errs++;
		end
		end_test("paging");
	endtask

	task automatic test_page_no_bit11();
		logic [15:0] old_page;
		logic [31:0] r;
		logic [15:0] a;
		logic [15:0] rd;
		logic [15:0] exp;
		old_page = page_cur;
		page_write({1'b0, old_page[14:12] + 3'd1, 1'b0, old_page[10:8] + 3'd1, 8'h00});
		r   = rand_bits(13);
		a   = 16'h4000 | ({3'b000, r[12:0]} << 1);
		exp = expect_word(cpu_to_phys(a, old_page));
		read_word(a, rd);
		if (rd !== exp) begin
			$display("error page_no_bit11: expected %h, actual %h", exp, rd);
			test_errs++;
		end
		end_test("page_no_bit11");
	endtask

	task automatic test_rom_protect();
		logic [31:0] r;
		logic [15:0] a;
		logic [15:0] rd;
		logic [15:0] exp;
		int          lat;
		r   = rand_bits(12);
		a   = 16'o140000 | {3'b000, r[11:0], 1'b0};
		exp = expect_word(cpu_to_phys(a, page_cur));
		r   = rand_bits(16);
		write_word(a, 2'b11, r[15:0], lat);
		if (lat != 2) begin
			$display("error rom_protect: expected ack after %0d, actual %0d", 2, lat);
			test_errs++;
		end
		read_word(a, rd);
		if (rd !== exp) begin
			$display("error rom_protect: expected %h, actual %h", exp, rd);
			test_errs++;
		end
		end_test("rom_protect");
	endtask

	task automatic test_refresh_reads();
		logic [31:0] r;
		logic [15:0] a;
		logic [15:0] rd;
		logic [15:0] exp;
		int          c0;
		int          r0;
		int          n;
		int          exp_n;
		c0 = cycle;
		r0 = refresh_cnt;
		for (int i = 0; i < N_REF_READS; i++) begin
			r   = rand_bits(13);
			a   = {2'b00, r[12:0], 1'b0};
			exp = expect_word(cpu_to_phys(a, page_cur));
			read_word(a, rd);
			if (rd !== exp) begin
				$display("error refresh_reads: expected %h, actual %h", exp, rd);
				test_errs++;
			end
		end
		n     = refresh_cnt - r0;
		exp_n = (cycle - c0) / `BK_SDRAM_REFRESH_CYCLES;
		if (n < exp_n - 1 || n > exp_n + 1) begin
			$display("error refresh_reads: expected %0d refreshes, actual %0d", exp_n, n);
			test_errs++;
		end
		if (exp_n < 3) begin
			$display("refresh_reads: only %0d refresh intervals were covered", exp_n);
			test_errs++;
		end
		end_test("refresh_reads");
	endtask

	//////////////////////////////////////////////////////////////////////
	// sequence and watchdog
	//////////////////////////////////////////////////////////////////////

	initial begin
		arst_n   = 1'b0;
		stb      = 1'b0;
		we       = 1'b0;
		sel      = 2'b00;
		adr      = '0;
		wdat     = '0;
		page_wr  = 1'b0;
		page_dat = '0;
		repeat (3) @(posedge clk_037);
		@(negedge clk_037);
		arst_n = 1'b1;
		@(negedge clk_037);
		test_startup();
		test_byte_writes();
		test_paging();
		test_page_no_bit11();
		test_rom_protect();
		test_refresh_reads();
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errs_total);
		if (errs_total == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT_CYCLES * 2 * CLK_HALF);
		$display("watchdog: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TEST FAIL");
		$finish;
	end

endmodule

/* verif/sdram_model.sv */
//////////////////////////////////////////////////////////////////////
// behavioural SDRAM, single word access, CAS latency from the config
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "bk_mem_config.svh"

module sdram_model (
	input  logic        clk_037,
	input  logic        cke_i,
	input  logic        ncs_i,
	input  logic        nras_i,
	input  logic        ncas_i,
	input  logic        nwe_i,
	input  logic [1:0]  ba_i,
	input  logic [12:0] a_i,
	input  logic        dqml_i,
	input  logic        dqmh_i,
	inout  wire  [15:0] dq_io,
	output int          refresh_cnt_o,
	output logic [12:0] mode_o
);

	localparam int DEPTH = 1048576;  // bottom of bank 0, covers every mapped address

	logic [15:0]              mem [DEPTH];
	bit                       written [DEPTH];
	logic [12:0]              open_row [4];
	logic [`BK_SDRAM_CAS-1:0] rd_pipe = '0;  // read data on its way out
	logic [15:0]              rd_word;
	logic [23:0]              word_addr;

	assign word_addr = {ba_i, open_row[ba_i], a_i[8:0]};
	assign dq_io     = rd_pipe[`BK_SDRAM_CAS-1] ? rd_word : 16'hzzzz;

	function automatic logic [15:0] word_at(input logic [23:0] wa);
		if (wa < DEPTH && written[wa[19:0]])
			return mem[wa[19:0]];
		return wa[15:0] ^ 16'hA5A5;  // power up content
	endfunction

	initial begin
		refresh_cnt_o = 0;
		mode_o        = '0;
	end

	// command decode on {ras, cas, we} while selected
	always @(posedge clk_037) begin
		logic [15:0] w;
		rd_pipe <= rd_pipe << 1;
		if (cke_i && !ncs_i) begin
			case ({nras_i, ncas_i, nwe_i})
				3'b011: open_row[ba_i] <= a_i;  // active
				3'b101: begin                   // read
					rd_word    <= word_at(word_addr);
					rd_pipe[0] <= 1'b1;
				end
				3'b100: begin                   // write, dqm low lets a byte in
					w = word_at(word_addr);
					if (!dqml_i)
						w[7:0] = dq_io[7:0];
					if (!dqmh_i)
						w[15:8] = dq_io[15:8];
					if (word_addr < DEPTH) begin
						mem[word_addr[19:0]]     <= w;
						written[word_addr[19:0]] <= 1'b1;
					end
				end
				3'b001: refresh_cnt_o <= refresh_cnt_o + 1;
				3'b000: mode_o <= a_i;
				default: ;
			endcase
		end
	end

endmodule
